// File: design/spi_reg_pkg.sv
package spi_reg_pkg;

    // Frame lengths on the SPI link, counted in clock pulses
    localparam int cmd_width = 56;
    localparam int rsp_width = 48;

    // Command frame as it arrives on MOSI, opcode first
    typedef struct packed {
        logic [7:0]  opcode;
        logic [15:0] addr;
        logic [31:0] data;
    } spi_cmd_t;

    // Response frame as it leaves on MISO, status first
    typedef struct packed {
        logic [7:0]  status;
        logic [31:0] data;
        logic [7:0]  seq;
    } spi_rsp_t;

    typedef enum logic [7:0] {
        op_nop   = 8'h00,
        op_write = 8'h01,
        op_read  = 8'h02
    } spi_op_e;

    typedef enum logic [7:0] {
        st_ok       = 8'h00,
        st_bad_op   = 8'h01,
        st_bad_addr = 8'h02
    } spi_status_e;

endpackage

// File: design/sync_sig.sv
`timescale 1ns/100ps

module sync_sig (
    input  logic clk,
    input  logic nrst,
    input  logic in_sig,
    output logic out_sig
);

    // First stage may go metastable, the second gives it a cycle to settle
    logic meta;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            meta    <= 1'b0;
            out_sig <= 1'b0;
        end else begin
            meta    <= in_sig;
            out_sig <= meta;
        end
    end

endmodule

// File: design/spi_iff.sv
`timescale 1ns/100ps

module spi_iff (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  spi_clk,
    input  logic                  spi_ss,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    input  spi_reg_pkg::spi_rsp_t rsp,
    output spi_reg_pkg::spi_cmd_t cmd,
    output logic                  valid
);

    logic sync_sck;
    logic sync_ss;
    logic sync_mosi;
    logic last_sck;
    logic last_ss;
    logic sck_rise;
    logic sck_fall;
    logic ss_rise;
    logic ss_fall;
    logic in_frame;

    logic [spi_reg_pkg::cmd_width-1:0] in_reg;
    logic [spi_reg_pkg::rsp_width-1:0] out_reg;

    sync_sig u_sync_sck (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_clk),
        .out_sig (sync_sck)
    );

    sync_sig u_sync_ss (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_ss),
        .out_sig (sync_ss)
    );

    sync_sig u_sync_mosi (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_mosi),
        .out_sig (sync_mosi)
    );

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_sck <= 1'b0;
            last_ss  <= 1'b0;
        end else begin
            last_sck <= sync_sck;
            last_ss  <= sync_ss;
        end
    end

    assign sck_rise = sync_sck & ~last_sck;
    assign sck_fall = ~sync_sck & last_sck;
    assign ss_rise  = sync_ss & ~last_ss;
    assign ss_fall  = ~sync_ss & last_ss;

    // The synchronizer leaves reset low, so slave select shows a rising edge
    // right after reset. Only a rise that closes a real frame counts
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_frame <= 1'b0;
        end else if (ss_fall) begin
            in_frame <= 1'b1;
        end else if (ss_rise) begin
            in_frame <= 1'b0;
        end
    end

    // MOSI is sampled on the rising SPI clock, MSB first
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_reg <= '0;
        end else if (ss_fall) begin
            in_reg <= '0;
        end else if (!sync_ss && sck_rise) begin
            in_reg <= {in_reg[spi_reg_pkg::cmd_width-2:0], sync_mosi};
        end
    end

    // Load the response when the frame opens, then move one bit per falling
    // clock. Zeros fill in behind, so the last 8 pulses of a frame read 0
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_reg <= '0;
        end else if (ss_fall) begin
            out_reg <= rsp;
        end else if (!sync_ss && sck_fall) begin
            out_reg <= {out_reg[spi_reg_pkg::rsp_width-2:0], 1'b0};
        end
    end

    assign spi_miso = out_reg[spi_reg_pkg::rsp_width-1];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= ss_rise & in_frame;
            if (ss_rise && in_frame) begin
                cmd <= spi_reg_pkg::spi_cmd_t'(in_reg);
            end
        end
    end

    valid_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
        valid |=> !valid)
        else $error("valid held high for more than one cycle");

    // The master only toggles the SPI clock inside a frame
    no_sck_outside_frame: assert property (@(posedge clk) disable iff (!nrst)
        sync_ss |-> !(sck_rise || sck_fall))
        else $error("SPI clock edge seen while slave select is high");

endmodule

// File: design/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder #(
    parameter int num_regs = 16
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  spi_reg_pkg::spi_cmd_t cmd,
    input  logic                  valid,
    output spi_reg_pkg::spi_rsp_t rsp
);

    localparam int idx_width = (num_regs > 1) ? $clog2(num_regs) : 1;

    logic [31:0]           regs [num_regs];
    logic [7:0]            seq;
    logic [7:0]            seq_next;
    logic                  addr_ok;
    logic [idx_width-1:0]  idx;
    logic                  wr_en;
    spi_reg_pkg::spi_rsp_t rsp_next;

    // The counter wraps at 256 on its own
    assign seq_next = seq + 8'd1;
    assign addr_ok  = int'(cmd.addr) < num_regs;
    assign idx      = cmd.addr[idx_width-1:0];

    // Build the response for the command now sitting on cmd
    always_comb begin
        wr_en           = 1'b0;
        rsp_next.status = spi_reg_pkg::st_ok;
        rsp_next.data   = '0;
        rsp_next.seq    = seq_next;
        case (cmd.opcode)
            spi_reg_pkg::op_nop: begin
                rsp_next.data = '0;
            end
            spi_reg_pkg::op_write: begin
                if (addr_ok) begin
                    wr_en         = 1'b1;
                    rsp_next.data = cmd.data;
                end else begin
                    rsp_next.status = spi_reg_pkg::st_bad_addr;
                end
            end
            spi_reg_pkg::op_read: begin
                if (addr_ok) begin
                    rsp_next.data = regs[idx];
                end else begin
                    rsp_next.status = spi_reg_pkg::st_bad_addr;
                end
            end
            default: begin
                rsp_next.status = spi_reg_pkg::st_bad_op;
            end
        endcase
    end

    // Register bank, counter and response all move only on valid
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            seq <= '0;
            rsp <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (valid) begin
            seq <= seq_next;
            rsp <= rsp_next;
            if (wr_en) begin
                regs[idx] <= cmd.data;
            end
        end
    end

    status_defined: assert property (@(posedge clk) disable iff (!nrst)
        rsp.status inside {spi_reg_pkg::st_ok, spi_reg_pkg::st_bad_op,
                           spi_reg_pkg::st_bad_addr})
        else $error("undefined status code 0x%02h", rsp.status);

endmodule

// File: design/spi_reg_top.sv
`timescale 1ns/100ps

module spi_reg_top #(
    parameter int num_regs = 16
) (
    input  logic clk,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic frame_done
);

    spi_reg_pkg::spi_cmd_t cmd;
    spi_reg_pkg::spi_rsp_t rsp;

    // The end of frame pulse also tells the outside that a command ran
    spi_iff u_spi_iff (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .rsp      (rsp),
        .cmd      (cmd),
        .valid    (frame_done)
    );

    cmd_decoder #(
        .num_regs (num_regs)
    ) u_cmd_decoder (
        .clk   (clk),
        .nrst  (nrst),
        .cmd   (cmd),
        .valid (frame_done),
        .rsp   (rsp)
    );

endmodule

// File: verification/spi_reg_tb.sv
`timescale 1ns/100ps

module spi_reg_tb;

    localparam int num_regs   = 16;
    localparam int half_sck   = 4;
    localparam int frame_gap  = 12;
    localparam int n_directed = 7;
    localparam int n_random   = 320;
    localparam int n_frames   = n_directed + n_random + num_regs + 1;

    logic clk;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    logic spi_miso;
    logic frame_done;

    // Reference model state
    logic [31:0]           model_regs [num_regs];
    logic [7:0]            model_seq;
    spi_reg_pkg::spi_rsp_t expected;

    int          frames_sent;
    int          done_count;
    int          rsp_errors;
    int          count_errors;
    int          other_errors;

    spi_reg_top #(
        .num_regs (num_regs)
    ) u_spi_reg_top (
        .clk        (clk),
        .nrst       (nrst),
        .spi_clk    (spi_clk),
        .spi_ss     (spi_ss),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done_count <= 0;
        end else if (frame_done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check_rsp(input spi_reg_pkg::spi_rsp_t got,
                             input spi_reg_pkg::spi_rsp_t exp);
        if (got.status !== exp.status) begin
            $display("Fail rsp.status in frame %0d: got 0x%02h expected 0x%02h",
                     frames_sent, got.status, exp.status);
            rsp_errors++;
        end
        if (got.data !== exp.data) begin
            $display("Fail rsp.data in frame %0d: got 0x%08h expected 0x%08h",
                     frames_sent, got.data, exp.data);
            rsp_errors++;
        end
        if (got.seq !== exp.seq) begin
            $display("Fail rsp.seq in frame %0d: got 0x%02h expected 0x%02h",
                     frames_sent, got.seq, exp.seq);
            rsp_errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            $display("Fail frame_done count: got 0x%0h expected 0x%0h", got, exp);
            count_errors++;
        end
    endtask

    // Expected response of one command, following the decoder rules
    task automatic apply_model(input spi_reg_pkg::spi_cmd_t c,
                               output spi_reg_pkg::spi_rsp_t r);
        model_seq = model_seq + 8'd1;
        r.status  = spi_reg_pkg::st_ok;
        r.data    = 32'h0;
        r.seq     = model_seq;
        if (c.opcode == spi_reg_pkg::op_write || c.opcode == spi_reg_pkg::op_read) begin
            if (c.addr >= 16'd16) begin
                r.status = spi_reg_pkg::st_bad_addr;
            end else if (c.opcode == spi_reg_pkg::op_write) begin
                model_regs[c.addr[3:0]] = c.data;
                r.data = c.data;
            end else begin
                r.data = model_regs[c.addr[3:0]];
            end
        end else if (c.opcode != spi_reg_pkg::op_nop) begin
            r.status = spi_reg_pkg::st_bad_op;
        end
    endtask

    // Mode 0 master, called on a falling clk edge
    task automatic send_frame(input spi_reg_pkg::spi_cmd_t c,
                              output spi_reg_pkg::spi_rsp_t r);
        logic [spi_reg_pkg::cmd_width-1:0] bits;
        logic [spi_reg_pkg::rsp_width-1:0] rx;
        logic [7:0]                        tail;
        bits   = c;
        rx     = '0;
        tail   = '0;
        spi_ss = 1'b0;
        for (int i = spi_reg_pkg::cmd_width - 1; i >= 0; i--) begin
            spi_mosi = bits[i];
            repeat (half_sck) @(negedge clk);
            spi_clk = 1'b1;
            if (i >= spi_reg_pkg::cmd_width - spi_reg_pkg::rsp_width) begin
                rx = {rx[spi_reg_pkg::rsp_width-2:0], spi_miso};
            end else begin
                tail = {tail[6:0], spi_miso};
            end
            repeat (half_sck) @(negedge clk);
            spi_clk = 1'b0;
        end
        repeat (half_sck) @(negedge clk);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        r = rx;
        if (tail != 8'h00) begin
            $display("MISO was not zero during the last 8 pulses of frame %0d", frames_sent);
            other_errors++;
        end
    endtask

    task automatic run_frame(input spi_reg_pkg::spi_cmd_t c);
        spi_reg_pkg::spi_rsp_t got;
        send_frame(c, got);
        // The frame just sent carries the answer to the one before it
        check_rsp(got, expected);
        apply_model(c, expected);
        frames_sent++;
        repeat (frame_gap) @(negedge clk);
    endtask

    function automatic spi_reg_pkg::spi_cmd_t make_cmd(input logic [7:0]  op,
                                                       input logic [15:0] addr,
                                                       input logic [31:0] data);
        spi_reg_pkg::spi_cmd_t c;
        c.opcode = op;
        c.addr   = addr;
        c.data   = data;
        return c;
    endfunction

    // Mostly valid opcodes and in-range addresses
    function automatic spi_reg_pkg::spi_cmd_t random_cmd();
        spi_reg_pkg::spi_cmd_t c;
        logic [31:0]           pick;
        logic [31:0]           rnd;
        pick = $urandom;
        rnd  = $urandom;
        if (pick[3:0] < 4'd6) begin
            c.opcode = spi_reg_pkg::op_write;
        end else if (pick[3:0] < 4'd11) begin
            c.opcode = spi_reg_pkg::op_read;
        end else if (pick[3:0] < 4'd13) begin
            c.opcode = spi_reg_pkg::op_nop;
        end else begin
            c.opcode = rnd[31:24];
        end
        if (pick[7:4] != 4'd0) begin
            c.addr = {12'h000, rnd[3:0]};
        end else begin
            c.addr = rnd[19:4];
            if (c.addr < 16'd16) begin
                c.addr[4] = 1'b1;
            end
        end
        c.data = $urandom;
        return c;
    endfunction

    initial begin
        #(n_frames * 500 * 8 + 20000);
        $display("Timeout: the frames did not all complete in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        nrst         = 1'b0;
        spi_clk      = 1'b0;
        spi_ss       = 1'b1;
        spi_mosi     = 1'b0;
        frames_sent  = 0;
        rsp_errors   = 0;
        count_errors = 0;
        other_errors = 0;
        expected     = '0;
        model_seq    = 8'h00;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = 32'h0;
        end
        void'($urandom(85805));
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        repeat (frame_gap) @(negedge clk);
        check_count(done_count, 0);

        run_frame(make_cmd(spi_reg_pkg::op_nop, 16'h0000, 32'h0));
        run_frame(make_cmd(spi_reg_pkg::op_write, 16'h0003, 32'hcafe_1234));
        run_frame(make_cmd(spi_reg_pkg::op_read, 16'h0003, 32'h0));
        run_frame(make_cmd(8'h5a, 16'h0003, 32'hdead_beef));
        run_frame(make_cmd(spi_reg_pkg::op_read, 16'h0003, 32'h0));
        run_frame(make_cmd(spi_reg_pkg::op_write, 16'h0010, 32'h1357_9bdf));
        run_frame(make_cmd(spi_reg_pkg::op_read, 16'hffff, 32'h0));

        for (int n = 0; n < n_random; n++) begin
            run_frame(random_cmd());
        end

        // Read back the whole bank, then one more frame to fetch the last answer
        for (int i = 0; i < num_regs; i++) begin
            run_frame(make_cmd(spi_reg_pkg::op_read, 16'(i), 32'h0));
        end
        run_frame(make_cmd(spi_reg_pkg::op_nop, 16'h0000, 32'h0));

        check_count(done_count, frames_sent);

        $display("Errors: response %0d, frame_done count %0d, other %0d, frames %0d",
                 rsp_errors, count_errors, other_errors, frames_sent);
        if (rsp_errors + count_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
design/spi_reg_pkg.sv
design/sync_sig.sv
design/spi_iff.sv
design/cmd_decoder.sv
design/spi_reg_top.sv
verification/spi_reg_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the SPI register slave testbench with Verilator

rm -f build.log sim.log

verilator --binary --timing --assert -f project.f --top-module spi_reg_tb \
    -o spi_reg_sim > build.log 2>&1 \
    && ./obj_dir/spi_reg_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
